/* hw/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ####################
// Memory map
// ####################

`define MIPS_RESET_PC     32'h4   // First instruction fetched after reset
`define MIPS_RAM_WORDS    64      // Covers the 8-bit loader byte address space

// ####################
// Timing and buffering
// ####################

`define MIPS_RAM_WAIT     2       // Cycles of waitrequest before readdata is good
`define MIPS_QUEUE_DEPTH  4       // Prefetch entries as a power of two

`endif

/* hw/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    // Primary opcode field
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // R-type selected by funct
        OP_REGIMM  = 6'h01,  // Selected by rt
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09
    } opcode_e;

    // Function field of SPECIAL
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_OR   = 6'h25
    } funct_e;

    // rt field of REGIMM
    typedef enum logic [4:0] {
        RI_BLTZ = 5'h00,
        RI_BGEZ = 5'h01
    } regimm_e;

    // Field view of one instruction word with the immediate in bits 15:0
    typedef struct packed {
        opcode_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } instr_t;

endpackage

`default_nettype wire

/* hw/mips_bus_pkg.sv */
`default_nettype none

package mips_bus_pkg;

    // One prefetched instruction
    typedef struct packed {
        logic [31:0] pc;     // Byte address it was read from
        logic [31:0] instr;  // Raw instruction word
    } queue_entry_t;

    // Control transfer request from execute
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* hw/avalon_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Read-only Avalon-MM instruction bus
interface avalon_if;

    logic [31:0] address;      // Byte address
    logic        read;
    logic        waitrequest;  // Slave stall, transfer completes when low
    logic [31:0] readdata;

    modport master (
        output address,
        output read,
        input  waitrequest,
        input  readdata
    );

    modport slave (
        input  address,
        input  read,
        output waitrequest,
        output readdata
    );

endinterface

`default_nettype wire

/* hw/avalon_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module avalon_ram (
    input  logic        clk,
    input  logic        rst,
    avalon_if.slave     bus,
    input  logic        inst_input,   // Loader write strobe
    input  logic [7:0]  inst_addr,    // Loader byte address
    input  logic [31:0] instruction   // Loader write data
);

    localparam int ADDR_W = $clog2(`MIPS_RAM_WORDS);
    localparam int WAIT_W = $clog2(`MIPS_RAM_WAIT + 1);

    logic [31:0]       mem [`MIPS_RAM_WORDS];
    logic [WAIT_W-1:0] wait_cnt;
    logic              done;

    // ####################
    // Loader port
    // ####################

    always_ff @(posedge clk) begin
        if (inst_input) begin
            mem[inst_addr[ADDR_W+1:2]] <= instruction;  // Word index from byte address
        end
    end

    // ####################
    // Bus read port
    // ####################

    assign bus.waitrequest = bus.read && (wait_cnt != WAIT_W'(`MIPS_RAM_WAIT));
    assign bus.readdata    = mem[bus.address[ADDR_W+1:2]];
    assign done            = bus.read && !bus.waitrequest;

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (done) begin
            wait_cnt <= '0;             // Ready for the next transfer
        end else if (bus.read) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/mips_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module mips_fetch import mips_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    avalon_if.master     bus,
    output logic         push,
    output queue_entry_t entry,
    input  logic         full,
    input  redirect_t    redirect,
    input  logic         active
);

    logic [31:0] pc;        // Next address to fetch
    logic [31:0] addr_q;    // Address of the outstanding read
    logic        pending;   // Read in flight
    logic        stale;     // Outstanding read was overtaken by a redirect
    logic        start;
    logic        done;

    // A new read is launched only with room in the queue, so every
    // completed read has a free slot waiting for it
    assign start = !pending && active && !full && !redirect.valid;
    assign done  = bus.read && !bus.waitrequest;

    assign bus.read    = pending || start;
    assign bus.address = pending ? addr_q : pc;  // Held stable while pending

    assign push        = done && !stale && !redirect.valid;
    assign entry.pc    = addr_q;
    assign entry.instr = bus.readdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            stale   <= 1'b0;
            pc      <= `MIPS_RESET_PC;
        end else begin
            if (start) begin
                pending <= 1'b1;
                pc      <= pc + 32'd4;
            end else if (done) begin
                pending <= 1'b0;
            end

            if (done) begin
                stale <= 1'b0;
            end else if (redirect.valid && pending) begin
                stale <= 1'b1;  // Let it finish and drop the data
            end

            if (redirect.valid) begin
                pc <= redirect.target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= pc;
        end
    end

endmodule

`default_nettype wire

/* hw/inst_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module inst_queue import mips_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         push,
    input  queue_entry_t push_entry,
    output logic         full,
    output logic         valid,
    input  logic         pop,
    output queue_entry_t pop_entry,
    input  logic         flush
);

    localparam int DEPTH = `MIPS_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    queue_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == (PTR_W+1)'(DEPTH));
    assign valid     = (count != '0);
    assign pop_entry = mem[rd_ptr];

    assign do_push = push && !full && !flush;  // Flush wins over push
    assign do_pop  = pop && valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps since depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/mips_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_exec import mips_isa_pkg::*, mips_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         valid,
    input  queue_entry_t entry,
    output logic         pop,
    output redirect_t    redirect,
    output logic         active,
    output logic [31:0]  register_v0
);

    logic [31:0] regs [32];
    instr_t      ir;
    logic [31:0] simm;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic        wr_en;
    logic [4:0]  wr_idx;
    logic [31:0] wr_data;
    logic        take;          // This instruction transfers control
    logic [31:0] target;
    logic        pend_valid;    // Transfer waiting for its delay slot
    logic [31:0] pend_target;
    logic        halt;
    logic        halted;

    // ####################
    // Decode and operands
    // ####################

    assign ir     = instr_t'(entry.instr);
    assign simm   = {{16{entry.instr[15]}}, entry.instr[15:0]};
    assign rs_val = (ir.rs == 5'd0) ? 32'd0 : regs[ir.rs];  // $zero
    assign rt_val = (ir.rt == 5'd0) ? 32'd0 : regs[ir.rt];

    assign pop         = valid && active;
    assign register_v0 = regs[2];

    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = ir.rt;
        wr_data = 32'd0;
        take    = 1'b0;
        target  = entry.pc + 32'd4 + {simm[29:0], 2'b00};  // Branch offset in words
        case (ir.op)
            OP_ADDIU: begin
                wr_en   = 1'b1;
                wr_data = rs_val + simm;
            end
            OP_SPECIAL: begin
                wr_idx = ir.rd;
                case (ir.funct)
                    FN_ADDU: begin
                        wr_en   = 1'b1;
                        wr_data = rs_val + rt_val;
                    end
                    FN_SUBU: begin
                        wr_en   = 1'b1;
                        wr_data = rs_val - rt_val;
                    end
                    FN_OR: begin
                        wr_en   = 1'b1;
                        wr_data = rs_val | rt_val;
                    end
                    FN_JR: begin
                        take   = 1'b1;
                        target = rs_val;
                    end
                    default: ;  // No-op
                endcase
            end
            OP_BEQ: take = (rs_val == rt_val);
            OP_BNE: take = (rs_val != rt_val);
            OP_REGIMM: begin
                case (ir.rt)
                    RI_BLTZ: take = rs_val[31];
                    RI_BGEZ: take = !rs_val[31];
                    default: ;
                endcase
            end
            default: ;  // Unsupported encodings do nothing
        endcase
    end

    // ####################
    // Delay slot and halt
    // ####################

    // The pending transfer is issued while the delay slot is popped
    assign redirect.valid  = pop && pend_valid && (pend_target != 32'd0);
    assign redirect.target = pend_target;
    assign halt            = pop && pend_valid && (pend_target == 32'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if (pop) begin
            pend_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && take) begin
            pend_target <= target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            halted <= 1'b0;
        end else if (halt) begin
            active <= 1'b0;
            halted <= 1'b1;  // Stays down until the next reset
        end else begin
            active <= !halted;
        end
    end

    // Registers restart from zero for every program
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (pop && wr_en && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* hw/mips_cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_top import mips_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_input,
    input  logic [7:0]  inst_addr,
    input  logic [31:0] instruction,
    output logic        active,
    output logic [31:0] register_v0
);

    queue_entry_t fetch_entry;  // Fetch to queue
    queue_entry_t exec_entry;   // Queue to execute
    logic         push;
    logic         full;
    logic         q_valid;
    logic         pop;
    redirect_t    redirect;

    avalon_if ibus ();

    avalon_ram u_ram (
        .clk         (clk),
        .rst         (rst),
        .bus         (ibus.slave),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction)
    );

    mips_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .bus      (ibus.master),
        .push     (push),
        .entry    (fetch_entry),
        .full     (full),
        .redirect (redirect),
        .active   (active)
    );

    inst_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (fetch_entry),
        .full       (full),
        .valid      (q_valid),
        .pop        (pop),
        .pop_entry  (exec_entry),
        .flush      (redirect.valid)  // Drop wrong-path prefetches
    );

    mips_exec u_exec (
        .clk         (clk),
        .rst         (rst),
        .valid       (q_valid),
        .entry       (exec_entry),
        .pop         (pop),
        .redirect    (redirect),
        .active      (active),
        .register_v0 (register_v0)
    );

endmodule

`default_nettype wire

/* testbench/tb_mips_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module tb_mips_cpu;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PROGRAMS = 12;
    localparam int WORDS        = `MIPS_RAM_WORDS;

    // Encodings from the MIPS instruction set
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_OR      = 6'h25;

    logic        clk;
    logic        rst;
    logic        inst_input;
    logic [7:0]  inst_addr;
    logic [31:0] instruction;
    logic        active;
    logic [31:0] register_v0;

    logic [31:0] prog [WORDS];  // Image loaded into the RAM
    logic [31:0] expected_v0;
    logic        active_q;
    int          errors;
    int          falls;         // Falling edges of active since reset
    int          since_rst;
    integer      seed;

    mips_cpu_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction),
        .active      (active),
        .register_v0 (register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ####################
    // Program images
    // ####################

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    // Unused words hold opcode 0x3f as a no-op tagged with their byte address
    task automatic fill_memory();
        for (int i = 0; i < WORDS; i++) begin
            prog[i] = {6'h3f, 18'h0, 8'(i * 4)};
        end
    endtask

    task automatic branch_program(input logic [31:0] br, input logic [15:0] v1_imm);
        fill_memory();
        prog[1] = itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h0010);
        prog[2] = itype_word(OP_ADDIU, 5'd0, 5'd3, v1_imm);
        prog[3] = br;                                           // Target is word 6
        prog[4] = itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0020);  // Delay slot
        prog[5] = itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0030);  // Skipped when taken
        prog[6] = itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0040);
        prog[7] = rtype_word(5'd0, 5'd0, 5'd0, FN_JR);
        prog[8] = 32'h0000_0000;
    endtask

    task automatic alu_program();
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        fill_memory();
        prog[1]  = itype_word(OP_ADDIU, 5'd0, 5'd8, a[15:0]);
        prog[2]  = itype_word(OP_ADDIU, 5'd0, 5'd9, b[15:0]);
        prog[3]  = rtype_word(5'd8, 5'd9, 5'd10, FN_ADDU);
        prog[4]  = rtype_word(5'd8, 5'd9, 5'd11, FN_SUBU);
        prog[5]  = rtype_word(5'd10, 5'd11, 5'd12, FN_OR);
        prog[6]  = itype_word(OP_ADDIU, 5'd0, 5'd0, a[31:16]);  // Writes to $zero
        prog[7]  = rtype_word(5'd12, 5'd9, 5'd0, FN_ADDU);
        prog[8]  = rtype_word(5'd12, 5'd0, 5'd2, FN_OR);
        prog[9]  = rtype_word(5'd0, 5'd0, 5'd0, FN_JR);
        prog[10] = 32'h0000_0000;
    endtask

    task automatic random_program();
        int          n;
        int          pick;
        logic [31:0] r;
        n = 1 + ($unsigned($random(seed)) % 36);  // Up to 40 words with the tail
        fill_memory();
        for (int i = 1; i <= n; i++) begin
            pick = $unsigned($random(seed)) % 4;
            r    = $random(seed);
            case (pick)
                0, 1:    prog[i] = itype_word(OP_ADDIU, 5'(r[19:16]), 5'(r[23:20]), r[15:0]);
                2:       prog[i] = rtype_word(5'(r[19:16]), 5'(r[23:20]), 5'(r[27:24]), FN_ADDU);
                default: prog[i] = rtype_word(5'(r[19:16]), 5'(r[23:20]), 5'(r[27:24]),
                                              r[31] ? FN_OR : FN_SUBU);
            endcase
        end
        prog[n + 1] = rtype_word(5'd2, 5'(r[3:0]), 5'd2, FN_ADDU);
        prog[n + 2] = rtype_word(5'd0, 5'd0, 5'd0, FN_JR);
        prog[n + 3] = itype_word(OP_ADDIU, 5'd2, 5'd2, {r[15:1], 1'b1});  // Delay slot of JR
        prog[n + 4] = itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0100);         // Beyond the halt
    endtask

    // ####################
    // Reference model
    // ####################

    task automatic run_model(output logic [31:0] v0, output int steps);
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] tgt;
        logic [31:0] pend_tgt;
        logic        pend;
        logic        take;
        bit          done;
        for (int i = 0; i < 32; i++) begin
            r[i] = 32'd0;
        end
        pc       = `MIPS_RESET_PC;
        pend     = 1'b0;
        pend_tgt = 32'd0;
        done     = 1'b0;
        steps    = 0;
        while (!done && steps < 1000) begin
            w    = prog[pc[7:2]];
            a    = r[w[25:21]];
            b    = r[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            take = 1'b0;
            tgt  = pc + 32'd4 + (simm << 2);
            case (w[31:26])
                OP_ADDIU:   r[w[20:16]] = a + simm;
                OP_SPECIAL: begin
                    case (w[5:0])
                        FN_ADDU: r[w[15:11]] = a + b;
                        FN_SUBU: r[w[15:11]] = a - b;
                        FN_OR:   r[w[15:11]] = a | b;
                        FN_JR: begin
                            take = 1'b1;
                            tgt  = a;
                        end
                        default: ;
                    endcase
                end
                OP_BEQ:    take = (a == b);
                OP_BNE:    take = (a != b);
                OP_REGIMM: begin
                    if (w[20:16] == 5'h00) take = a[31];   // BLTZ
                    if (w[20:16] == 5'h01) take = !a[31];  // BGEZ
                end
                default: ;
            endcase
            r[0]  = 32'd0;
            steps = steps + 1;
            if (pend) begin  // This was the delay slot
                pc   = pend_tgt;
                done = (pend_tgt == 32'd0);
            end else begin
                pc = pc + 32'd4;
            end
            pend     = take;
            pend_tgt = tgt;
        end
        v0 = r[2];
    endtask

    // ####################
    // Load and run
    // ####################

    task automatic load_and_reset();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < WORDS; i++) begin
            @(posedge clk);
            inst_input  <= 1'b1;
            inst_addr   <= 8'(i * 4);
            instruction <= prog[i];
        end
        @(posedge clk);
        inst_input <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_program(input string name);
        logic [31:0] exp_v0;
        int          steps;
        int          bound;
        int          waited;
        run_model(exp_v0, steps);
        expected_v0 = exp_v0;
        bound       = steps * 8 + 40;  // Eight cycles a step plus flush slack
        load_and_reset();
        waited = 0;
        while (falls == 0 && waited < bound) begin
            @(posedge clk);
            waited = waited + 1;
        end
        assert (falls != 0) else begin
            $display("%0t: program %s did not halt within %0d cycles", $time, name, bound);
            errors = errors + 1;
        end
        repeat (20) @(posedge clk);
        assert (falls <= 1) else begin
            $display("%0t: program %s dropped active %0d times", $time, name, falls);
            errors = errors + 1;
        end
    endtask

    // Outputs are sampled on the falling edge away from DUT updates
    always @(negedge clk) begin
        if (rst) begin
            assert (active === 1'b0) else begin
                $display("%0t: active is not low during reset", $time);
                errors = errors + 1;
            end
            since_rst = 0;
            falls     = 0;
            active_q  = 1'b0;
        end else begin
            if (since_rst == 1) begin
                assert (active === 1'b1) else begin
                    $display("%0t: active did not rise on the first clock after reset", $time);
                    errors = errors + 1;
                end
            end
            if (active_q && !active) begin
                falls = falls + 1;
                assert (register_v0 === expected_v0) else begin
                    $display("FAIL %0t register_v0 got %h expected %h",
                             $time, register_v0, expected_v0);
                    errors = errors + 1;
                end
            end
            if (falls != 0) begin
                assert (active === 1'b0) else begin
                    $display("%0t: active came back after the halt", $time);
                    errors = errors + 1;
                end
            end
            active_q  = active;
            since_rst = since_rst + 1;
        end
    end

    initial begin
        #(NUM_PROGRAMS * 400 * CLK_PERIOD);
        $display("Watchdog expired with %0d errors counted", errors);
        $display("TB FAILED");
        $finish;
    end

    // ####################
    // Test sequence
    // ####################

    initial begin
        seed        = 32'ha27a_85b3;
        errors      = 0;
        falls       = 0;
        since_rst   = 0;
        active_q    = 1'b0;
        expected_v0 = 32'd0;
        rst         = 1'b1;
        inst_input  = 1'b0;
        inst_addr   = 8'd0;
        instruction = 32'd0;

        branch_program(itype_word(OP_REGIMM, 5'd3, 5'h01, 16'd2), 16'h0010);
        run_program("bgez taken");
        branch_program(itype_word(OP_REGIMM, 5'd3, 5'h01, 16'd2), 16'hfff0);
        run_program("bgez not taken");
        branch_program(itype_word(OP_REGIMM, 5'd3, 5'h00, 16'd2), 16'hfff0);
        run_program("bltz taken");
        branch_program(itype_word(OP_REGIMM, 5'd3, 5'h00, 16'd2), 16'h0010);
        run_program("bltz not taken");
        branch_program(itype_word(OP_BEQ, 5'd2, 5'd3, 16'd2), 16'h0010);
        run_program("beq taken");
        branch_program(itype_word(OP_BEQ, 5'd2, 5'd3, 16'd2), 16'h0011);
        run_program("beq not taken");
        branch_program(itype_word(OP_BNE, 5'd2, 5'd3, 16'd2), 16'h0011);
        run_program("bne taken");
        branch_program(itype_word(OP_BNE, 5'd2, 5'd3, 16'd2), 16'h0010);
        run_program("bne not taken");

        alu_program();
        run_program("register alu");

        repeat (3) begin
            random_program();
            run_program("random straight line");
        end

        $display("Checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/mips_isa_pkg.sv
hw/mips_bus_pkg.sv
hw/avalon_if.sv
hw/avalon_ram.sv
hw/mips_fetch.sv
hw/inst_queue.sv
hw/mips_exec.sv
hw/mips_cpu_top.sv
testbench/tb_mips_cpu.sv

/* Bender.yml */
package:
  name: mips_cpu

export_include_dirs:
  - hw

sources:
  - hw/mips_isa_pkg.sv
  - hw/mips_bus_pkg.sv
  - hw/avalon_if.sv
  - hw/avalon_ram.sv
  - hw/mips_fetch.sv
  - hw/inst_queue.sv
  - hw/mips_exec.sv
  - hw/mips_cpu_top.sv
  - target: test
    files:
      - testbench/tb_mips_cpu.sv
